// File: rtl/psgPkg.sv
`default_nettype none

// ============================================================================
// wave table fetch path, shared sizes
// ============================================================================

package psgPkg;

	// eight wave channels, numbered 0 to 7
	localparam int NumChannels = 8;
	localparam int ChanWidth = 3;

	// 256-entry wave table per channel
	localparam int IndexWidth = 8;

	// sample memory address is {channel, index}
	localparam int AddrWidth = ChanWidth + IndexWidth;

	// signed samples
	localparam int SampleWidth = 12;

	// phase step and accumulator, index is the top IndexWidth bits
	localparam int StepWidth = 16;

	// room for eight full-scale samples
	localparam int MixWidth = SampleWidth + ChanWidth;

	// host register address: {channel, field}, field 0 step, field 1 enable
	localparam int RegAddrWidth = ChanWidth + 1;

endpackage

`default_nettype wire

// File: rtl/psgChannelRegs.sv
`timescale 1ns/1ps
`default_nettype none

module psgChannelRegs (
	input wire clk,
	input wire rst,
	input wire regWr,
	input wire [psgPkg::RegAddrWidth-1:0] regAddr,
	input wire [psgPkg::StepWidth-1:0] regData,
	output logic [psgPkg::StepWidth-1:0] step [psgPkg::NumChannels],
	output logic [psgPkg::NumChannels-1:0] enable,
	output logic [psgPkg::NumChannels-1:0] startPulse
);

	logic [psgPkg::ChanWidth-1:0] wrChan;
	logic wrField;

	// upper bits pick the channel, bit 0 picks the field
	assign wrChan = regAddr[psgPkg::RegAddrWidth-1:1];
	assign wrField = regAddr[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < psgPkg::NumChannels; i++) begin
				step[i] <= '0;
			end
			enable <= '0;
			startPulse <= '0;
		end else begin
			// start pulse lasts a single cycle
			startPulse <= '0;
			if (regWr) begin
				if (wrField) begin
					enable[wrChan] <= regData[0];
					startPulse[wrChan] <= regData[0];
				end else begin
					step[wrChan] <= regData;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/psgWaveChannel.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveChannel (
	input wire clk,
	input wire rst,
	input wire ce,
	input wire [psgPkg::StepWidth-1:0] step,
	input wire enable,
	input wire startPulse,
	input wire chanAck,
	input wire signed [psgPkg::SampleWidth-1:0] memData,
	output logic req,
	output logic [psgPkg::IndexWidth-1:0] fetchIndex,
	output logic signed [psgPkg::SampleWidth-1:0] sample
);

	logic [psgPkg::StepWidth-1:0] phase;
	logic [psgPkg::StepWidth-1:0] nextPhase;
	logic indexMoved;
	logic signed [psgPkg::SampleWidth-1:0] held;

	assign nextPhase = phase + step;

	// table index is the top of the accumulator
	assign fetchIndex = phase[psgPkg::StepWidth-1 -: psgPkg::IndexWidth];
	assign indexMoved = nextPhase[psgPkg::StepWidth-1 -: psgPkg::IndexWidth] != fetchIndex;

	// a disabled channel contributes nothing
	assign sample = enable ? held : '0;

	// ========================================================================
	// phase accumulator and fetch request
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
			req <= 1'b0;
		end else if (startPulse) begin
			// restart at index 0 and fetch it right away
			phase <= '0;
			req <= 1'b1;
		end else if (!enable) begin
			req <= 1'b0;
		end else begin
			if (chanAck) begin
				req <= 1'b0;
			end
			// a fresh index move wins over the ack of the old one
			if (ce) begin
				phase <= nextPhase;
				if (indexMoved) begin
					req <= 1'b1;
				end
			end
		end
	end

	// sample latch, loaded when the bus master hands back our data
	always_ff @(posedge clk) begin
		if (rst) begin
			held <= '0;
		end else if (chanAck) begin
			held <= memData;
		end
	end

endmodule

`default_nettype wire

// File: rtl/psgBusArb.sv
`timescale 1ns/1ps
`default_nettype none

module psgBusArb (
	input wire clk,
	input wire rst,
	input wire ce,
	input wire ack,
	input wire [psgPkg::NumChannels-1:0] req,
	output logic [psgPkg::NumChannels-1:0] sel,
	output logic [psgPkg::ChanWidth-1:0] seln
);

	logic anyReq;
	logic [psgPkg::ChanWidth-1:0] winner;

	assign anyReq = |req;

	// fixed priority, lowest channel number wins
	always_comb begin
		winner = '0;
		for (int i = psgPkg::NumChannels - 1; i >= 0; i--) begin
			if (req[i]) begin
				winner = psgPkg::ChanWidth'(i);
			end
		end
	end

	// re-arbitrate only on a ce cycle where the transfer has ended
	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			seln <= '0;
		end else if (ce && ack && anyReq) begin
			sel <= psgPkg::NumChannels'(1) << winner;
			seln <= winner;
		end
		// with no request the last owner keeps the bus
	end

endmodule

`default_nettype wire

// File: rtl/psgBusMaster.sv
`timescale 1ns/1ps
`default_nettype none

module psgBusMaster (
	input wire clk,
	input wire rst,
	input wire ce,
	input wire [psgPkg::NumChannels-1:0] req,
	input wire [psgPkg::IndexWidth-1:0] fetchIndex [psgPkg::NumChannels],
	input wire memAck,
	input wire signed [psgPkg::SampleWidth-1:0] memData,
	output logic memCyc,
	output logic [psgPkg::AddrWidth-1:0] memAdr,
	output logic [psgPkg::NumChannels-1:0] chanAck,
	output logic signed [psgPkg::SampleWidth-1:0] busData
);

	logic [psgPkg::NumChannels-1:0] sel;
	logic [psgPkg::ChanWidth-1:0] seln;
	logic [psgPkg::NumChannels-1:0] arbReq;
	logic ownerReq;
	logic cycEnd;
	logic cycStart;
	logic arbAck;

	// owner is valid only once a grant has been made
	assign ownerReq = |(sel & req);
	assign cycEnd = memCyc & memAck;
	assign cycStart = ~memCyc & ownerReq;

	// transfer ends on memAck, or straight away when the owner has nothing to do
	assign arbAck = cycEnd | (~memCyc & ~ownerReq);

	// the channel being acked drops out of this grant, its req is still high
	assign arbReq = req & ~chanAck;

	assign chanAck = cycEnd ? sel : '0;
	assign busData = memData;

	psgBusArb busArb_i (
		.clk (clk),
		.rst (rst),
		.ce (ce),
		.ack (arbAck),
		.req (arbReq),
		.sel (sel),
		.seln (seln)
	);

	// ========================================================================
	// memory cycle
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			memCyc <= 1'b0;
		end else if (cycEnd) begin
			memCyc <= 1'b0;
		end else if (cycStart) begin
			memCyc <= 1'b1;
		end
	end

	// address is held for the whole cycle, a slow memory stalls the bus
	always_ff @(posedge clk) begin
		if (cycStart) begin
			memAdr <= {seln, fetchIndex[seln]};
		end
	end

endmodule

`default_nettype wire

// File: rtl/psgMixer.sv
`timescale 1ns/1ps
`default_nettype none

module psgMixer (
	input wire clk,
	input wire rst,
	input wire ce,
	input wire [psgPkg::NumChannels-1:0] enable,
	input wire signed [psgPkg::SampleWidth-1:0] samples [psgPkg::NumChannels],
	output logic signed [psgPkg::MixWidth-1:0] mix
);

	localparam int ExtWidth = psgPkg::MixWidth - psgPkg::SampleWidth;

	logic signed [psgPkg::MixWidth-1:0] sum;

	// sign-extend each enabled sample and add
	always_comb begin
		sum = '0;
		for (int i = 0; i < psgPkg::NumChannels; i++) begin
			if (enable[i]) begin
				sum = sum + {{ExtWidth{samples[i][psgPkg::SampleWidth-1]}}, samples[i]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mix <= '0;
		end else if (ce) begin
			mix <= sum;
		end
	end

endmodule

`default_nettype wire

// File: rtl/psgWaveFetch.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveFetch (
	input wire clk,
	input wire rst,
	input wire ce,
	input wire regWr,
	input wire [psgPkg::RegAddrWidth-1:0] regAddr,
	input wire [psgPkg::StepWidth-1:0] regData,
	input wire memAck,
	input wire signed [psgPkg::SampleWidth-1:0] memData,
	output logic memCyc,
	output logic [psgPkg::AddrWidth-1:0] memAdr,
	output logic signed [psgPkg::MixWidth-1:0] mix
);

	logic [psgPkg::StepWidth-1:0] step [psgPkg::NumChannels];
	logic [psgPkg::NumChannels-1:0] enable;
	logic [psgPkg::NumChannels-1:0] startPulse;
	logic [psgPkg::NumChannels-1:0] req;
	logic [psgPkg::NumChannels-1:0] chanAck;
	logic [psgPkg::IndexWidth-1:0] fetchIndex [psgPkg::NumChannels];
	logic signed [psgPkg::SampleWidth-1:0] sample [psgPkg::NumChannels];
	logic signed [psgPkg::SampleWidth-1:0] busData;

	psgChannelRegs channelRegs_i (
		.clk (clk),
		.rst (rst),
		.regWr (regWr),
		.regAddr (regAddr),
		.regData (regData),
		.step (step),
		.enable (enable),
		.startPulse (startPulse)
	);

	// ========================================================================
	// wave channels
	// ========================================================================

	for (genvar ch = 0; ch < psgPkg::NumChannels; ch++) begin : gChan
		psgWaveChannel waveChannel_i (
			.clk (clk),
			.rst (rst),
			.ce (ce),
			.step (step[ch]),
			.enable (enable[ch]),
			.startPulse (startPulse[ch]),
			.chanAck (chanAck[ch]),
			.memData (busData),
			.req (req[ch]),
			.fetchIndex (fetchIndex[ch]),
			.sample (sample[ch])
		);
	end

	psgBusMaster busMaster_i (
		.clk (clk),
		.rst (rst),
		.ce (ce),
		.req (req),
		.fetchIndex (fetchIndex),
		.memAck (memAck),
		.memData (memData),
		.memCyc (memCyc),
		.memAdr (memAdr),
		.chanAck (chanAck),
		.busData (busData)
	);

	psgMixer mixer_i (
		.clk (clk),
		.rst (rst),
		.ce (ce),
		.enable (enable),
		.samples (sample),
		.mix (mix)
	);

endmodule

`default_nettype wire

// File: testbench/psgWaveFetchTb.sv
`timescale 1ns/1ps
`default_nettype none

module psgWaveFetchTb;

	// upper bound on the length of the whole sequence
	localparam int TimeoutCycles = 4000;
	localparam int IdleCycles = 20;

	logic clk = 1'b0;
	logic rst;
	logic ce;
	logic regWr;
	logic [psgPkg::RegAddrWidth-1:0] regAddr;
	logic [psgPkg::StepWidth-1:0] regData;
	logic memAck;
	logic signed [psgPkg::SampleWidth-1:0] memData;
	logic memCyc;
	logic [psgPkg::AddrWidth-1:0] memAdr;
	logic signed [psgPkg::MixWidth-1:0] mix;

	// bus monitor state
	logic [psgPkg::AddrWidth-1:0] doneAdr [$];
	logic [psgPkg::AddrWidth-1:0] lastAdr [psgPkg::NumChannels];
	logic [psgPkg::NumChannels-1:0] lastValid;
	logic [psgPkg::NumChannels-1:0] tbEnable;
	logic [psgPkg::AddrWidth-1:0] curAdr;
	logic inCycle;
	logic ceSeen;
	int idleCount = 0;
	int cycleCount = 0;
	logic [31:0] memRand = 32'd12;
	logic [31:0] ceRand = 32'd12;

	psgWaveFetch psgWaveFetch_i (
		.clk (clk),
		.rst (rst),
		.ce (ce),
		.regWr (regWr),
		.regAddr (regAddr),
		.regData (regData),
		.memAck (memAck),
		.memData (memData),
		.memCyc (memCyc),
		.memAdr (memAdr),
		.mix (mix)
	);

	always #10 clk = ~clk;

	// =========================================================================
	// reference functions
	// =========================================================================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// wave table contents as a hash of the whole address
	function automatic logic signed [psgPkg::SampleWidth-1:0] waveData(
		input logic [psgPkg::AddrWidth-1:0] adr
	);
		logic [23:0] h;
		h = (24'(adr) + 24'd1) * 24'd40503;
		h = h ^ (h >> 9);
		return h[psgPkg::SampleWidth-1:0];
	endfunction

	// channel never fetched still holds its reset sample of zero
	function automatic logic signed [psgPkg::MixWidth-1:0] expectedMix();
		logic signed [psgPkg::MixWidth-1:0] acc;
		acc = '0;
		for (int i = 0; i < psgPkg::NumChannels; i++) begin
			if (tbEnable[i] && lastValid[i]) begin
				acc = acc + psgPkg::MixWidth'(waveData(lastAdr[i]));
			end
		end
		return acc;
	endfunction

	function automatic logic [psgPkg::AddrWidth-1:0] chanAddr(input int ch, input int idx);
		return {ch[psgPkg::ChanWidth-1:0], idx[psgPkg::IndexWidth-1:0]};
	endfunction

	// =========================================================================
	// compare and drive tasks
	// =========================================================================

	task automatic failStop();
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkAddr(input string name, input logic [psgPkg::AddrWidth-1:0] got,
		input logic [psgPkg::AddrWidth-1:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			failStop();
		end
	endtask

	task automatic checkMix(input string name, input logic signed [psgPkg::MixWidth-1:0] got,
		input logic signed [psgPkg::MixWidth-1:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			failStop();
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			failStop();
		end
	endtask

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic regWrite(input int ch, input logic field,
		input logic [psgPkg::StepWidth-1:0] data);
		regAddr = {ch[psgPkg::ChanWidth-1:0], field};
		regData = data;
		regWr = 1'b1;
		tick();
		regWr = 1'b0;
		if (field) begin
			tbEnable[ch] = data[0];
		end
	endtask

	task automatic waitIdle();
		repeat (IdleCycles) tick();
		while (idleCount < IdleCycles) tick();
	endtask

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("timeout: the test sequence did not finish in %0d cycles", TimeoutCycles);
			failStop();
		end
	end

	// bus monitor samples on the falling edge where everything is settled
	always @(negedge clk) begin
		if (rst) begin
			inCycle = 1'b0;
			ceSeen = 1'b0;
			idleCount = 0;
			lastValid = '0;
		end else begin
			if (memCyc) begin
				idleCount = 0;
				if (!inCycle) begin
					if (!ceSeen) begin
						$display("bus cycle to 0x%h started with ce low since the last memAck",
							memAdr);
						failStop();
					end
					inCycle = 1'b1;
					curAdr = memAdr;
				end
				// address must not move while the memory stalls
				checkAddr("memAdr", memAdr, curAdr);
				if (memAck) begin
					doneAdr.push_back(curAdr);
					lastAdr[curAdr[psgPkg::AddrWidth-1 -: psgPkg::ChanWidth]] = curAdr;
					lastValid[curAdr[psgPkg::AddrWidth-1 -: psgPkg::ChanWidth]] = 1'b1;
					inCycle = 1'b0;
				end
			end else begin
				idleCount++;
			end
			// only a ce at or after the ack edge can hand the bus over
			ceSeen = (memCyc && memAck) ? ce : (ceSeen | ce);
		end
	end

	// memory model answers after a random latency of 1 to 6 cycles
	initial begin
		int delay;
		memAck = 1'b0;
		memData = '0;
		forever begin
			tick();
			if (!rst && memCyc) begin
				memRand = xorshift(memRand);
				delay = 1 + int'(memRand % 6);
				repeat (delay - 1) tick();
				memAck = 1'b1;
				memData = waveData(memAdr);
				tick();
				memAck = 1'b0;
				memData = '0;
			end
		end
	end

	// =========================================================================
	// test sequence
	// =========================================================================

	initial begin
		int order [5];
		int gap;
		logic [psgPkg::AddrWidth-1:0] got;
		order = '{0, 2, 4, 6, 7};
		rst = 1'b1;
		ce = 1'b1;
		regWr = 1'b0;
		regAddr = '0;
		regData = '0;
		tbEnable = '0;
		repeat (5) tick();
		rst = 1'b0;

		repeat (10) begin
			tick();
			checkBit("memCyc", memCyc, 1'b0);
			checkMix("mix", mix, '0);
		end

		// requests pile up while ce is low and drain lowest channel first
		ce = 1'b0;
		regWrite(6, 1'b1, 16'd1);
		regWrite(2, 1'b1, 16'd1);
		regWrite(7, 1'b1, 16'd1);
		regWrite(0, 1'b1, 16'd1);
		regWrite(4, 1'b1, 16'd1);
		repeat (3) tick();
		ce = 1'b1;
		while (doneAdr.size() < 5) tick();
		waitIdle();
		if (doneAdr.size() != 5) begin
			$display("expected 5 bus cycles after the start requests, saw %0d", doneAdr.size());
			failStop();
		end
		foreach (order[i]) begin
			got = doneAdr.pop_front();
			checkAddr("memAdr", got, chanAddr(order[i], 0));
		end
		checkMix("mix", mix, expectedMix());

		regWrite(0, 1'b1, 16'd0);
		regWrite(4, 1'b1, 16'd0);
		regWrite(7, 1'b1, 16'd0);
		// a disabled channel stays frozen whatever its step
		regWrite(0, 1'b0, 16'd256);
		regWrite(4, 1'b0, 16'd256);
		regWrite(7, 1'b0, 16'd256);
		waitIdle();
		if (doneAdr.size() != 0) begin
			$display("%0d bus cycles started after channels were disabled", doneAdr.size());
			failStop();
		end
		checkMix("mix", mix, expectedMix());

		// channel 3 steps one index per ce pulse
		// the first ce both grants the bus and steps the phase so index 1 comes first
		ce = 1'b0;
		regWrite(3, 1'b0, 16'd256);
		regWrite(3, 1'b1, 16'd1);
		repeat (2) tick();
		for (int k = 1; k <= 16; k++) begin
			ceRand = xorshift(ceRand);
			gap = int'(ceRand % 6);
			repeat (gap) tick();
			ce = 1'b1;
			tick();
			ce = 1'b0;
			while (doneAdr.size() == 0) tick();
			got = doneAdr.pop_front();
			checkAddr("memAdr", got, chanAddr(3, k));
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
rtl/psgPkg.sv
rtl/psgChannelRegs.sv
rtl/psgWaveChannel.sv
rtl/psgBusArb.sv
rtl/psgBusMaster.sv
rtl/psgMixer.sv
rtl/psgWaveFetch.sv
testbench/psgWaveFetchTb.sv

// File: run.sh
#!/bin/sh
# compile and run the wave fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module psgWaveFetchTb -o psgWaveFetchSim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

output=$(./obj_dir/psgWaveFetchSim 2>&1)
runStatus=$?
echo "$output"
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

if echo "$output" | grep -q "^SIMULATION PASSED$"; then
	exit 0
fi
exit 1
